/* hw/mpram_cfg_pkg.sv */
package mpram_cfg_pkg;

    // Storage geometry
    localparam int WORD_WIDTH = 16;
    localparam int DEPTH = 32;
    localparam int BANK_SIZE = 8;
    localparam int NUM_BANKS = DEPTH / BANK_SIZE;

    // Port counts
    localparam int READ_PORTS = 2;
    localparam int WRITE_PORTS = 2;

    // Address split, bank select on top
    localparam int ADDR_WIDTH = $clog2(DEPTH);
    localparam int BANK_ADDR_WIDTH = $clog2(BANK_SIZE);
    localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS);

    // Value written into every word after reset
    localparam logic [WORD_WIDTH-1:0] CLEAR_VALUE = 16'h0000;

endpackage

/* hw/mpram_types_pkg.sv */
package mpram_types_pkg;

    import mpram_cfg_pkg::*;

    // One stored word
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Full address as seen from outside
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Word offset inside one bank
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // Bank index, upper address bits
    typedef logic [BANK_SEL_WIDTH-1:0] bank_sel_t;

endpackage

/* hw/mpram_clear_seq.sv */
`timescale 1ns/1ps

module mpram_clear_seq (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        clear_active,
    output mpram_types_pkg::bank_addr_t clear_addr,
    output logic                        ready
);

    import mpram_cfg_pkg::*;
    import mpram_types_pkg::*;

    logic [BANK_ADDR_WIDTH:0] count; // One extra bit to reach BANK_SIZE
    logic                     clearing;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count    <= '0;
            clearing <= 1'b1;
            ready    <= 1'b0;
        end else if (clearing) begin
            count <= count + 1'b1;
            if (count == (BANK_ADDR_WIDTH + 1)'(BANK_SIZE)) begin
                clearing <= 1'b0; // Walk done
                ready    <= 1'b1;
            end
        end
    end

    assign clear_active = clearing;
    assign clear_addr   = bank_addr_t'(count); // Wraps to 0 on the final step

endmodule

/* hw/mpram_bank_route.sv */
`timescale 1ns/1ps

module mpram_bank_route (
    input  logic                        en [mpram_cfg_pkg::READ_PORTS],
    input  mpram_types_pkg::addr_t      raddr [mpram_cfg_pkg::READ_PORTS],
    input  logic                        we [mpram_cfg_pkg::WRITE_PORTS],
    input  mpram_types_pkg::addr_t      waddr [mpram_cfg_pkg::WRITE_PORTS],
    input  mpram_types_pkg::word_t      wdata [mpram_cfg_pkg::WRITE_PORTS],
    input  logic                        clear_active,
    input  mpram_types_pkg::bank_addr_t clear_addr,
    output mpram_types_pkg::bank_addr_t bank_raddr [mpram_cfg_pkg::READ_PORTS],
    output logic                        bank_ren [mpram_cfg_pkg::NUM_BANKS]
                                                 [mpram_cfg_pkg::READ_PORTS],
    output mpram_types_pkg::bank_addr_t bank_waddr [mpram_cfg_pkg::WRITE_PORTS],
    output mpram_types_pkg::word_t      bank_wdata [mpram_cfg_pkg::WRITE_PORTS],
    output logic                        bank_we [mpram_cfg_pkg::NUM_BANKS]
                                                [mpram_cfg_pkg::WRITE_PORTS],
    output mpram_types_pkg::bank_sel_t  rsel [mpram_cfg_pkg::READ_PORTS]
);

    import mpram_cfg_pkg::*;
    import mpram_types_pkg::*;

    bank_sel_t rbank [READ_PORTS];
    bank_sel_t wbank [WRITE_PORTS];

    // Read side
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rbank[p]      = raddr[p][ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
            bank_raddr[p] = raddr[p][BANK_ADDR_WIDTH-1:0];
            rsel[p]       = rbank[p];
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_ren[b][p] = en[p] && (rbank[p] == bank_sel_t'(b)); // One-hot per port
            end
        end
    end

    // Write side, clear takes over port 0 in every bank
    always_comb begin
        for (int w = 0; w < WRITE_PORTS; w++) begin
            wbank[w]      = waddr[w][ADDR_WIDTH-1 -: BANK_SEL_WIDTH];
            bank_waddr[w] = waddr[w][BANK_ADDR_WIDTH-1:0];
            bank_wdata[w] = wdata[w];
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_we[b][w] = we[w] && !clear_active && (wbank[w] == bank_sel_t'(b));
            end
        end
        if (clear_active) begin
            bank_waddr[0] = clear_addr;
            bank_wdata[0] = CLEAR_VALUE;
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_we[b][0] = 1'b1; // All banks cleared in parallel
            end
        end
    end

endmodule

/* hw/mpram_bank.sv */
`timescale 1ns/1ps

module mpram_bank (
    input  logic                        clk,
    input  mpram_types_pkg::bank_addr_t bank_raddr [mpram_cfg_pkg::READ_PORTS],
    input  logic                        ren [mpram_cfg_pkg::READ_PORTS],
    input  mpram_types_pkg::bank_addr_t bank_waddr [mpram_cfg_pkg::WRITE_PORTS],
    input  mpram_types_pkg::word_t      bank_wdata [mpram_cfg_pkg::WRITE_PORTS],
    input  logic                        we [mpram_cfg_pkg::WRITE_PORTS],
    output mpram_types_pkg::word_t      rdata [mpram_cfg_pkg::READ_PORTS]
);

    import mpram_cfg_pkg::*;
    import mpram_types_pkg::*;

    word_t mem [BANK_SIZE];

    // Higher port index is applied last and wins on equal offsets
    always_ff @(posedge clk) begin
        for (int w = 0; w < WRITE_PORTS; w++) begin
            if (we[w]) begin
                mem[bank_waddr[w]] <= bank_wdata[w];
            end
        end
    end

    // Registered reads see the word from before this edge
    always_ff @(posedge clk) begin
        for (int p = 0; p < READ_PORTS; p++) begin
            if (ren[p]) begin
                rdata[p] <= mem[bank_raddr[p]];
            end
        end
    end

endmodule

/* hw/mpram_read_select.sv */
`timescale 1ns/1ps

module mpram_read_select (
    input  logic                       clk,
    input  logic                       en [mpram_cfg_pkg::READ_PORTS],
    input  mpram_types_pkg::bank_sel_t rsel [mpram_cfg_pkg::READ_PORTS],
    input  mpram_types_pkg::word_t     bank_rdata [mpram_cfg_pkg::NUM_BANKS]
                                                  [mpram_cfg_pkg::READ_PORTS],
    output mpram_types_pkg::word_t     rdata [mpram_cfg_pkg::READ_PORTS]
);

    import mpram_cfg_pkg::*;
    import mpram_types_pkg::*;

    bank_sel_t sel_q [READ_PORTS];

    // Sampled at the same edge as the bank read
    always_ff @(posedge clk) begin
        for (int p = 0; p < READ_PORTS; p++) begin
            if (en[p]) begin
                sel_q[p] <= rsel[p];
            end
        end
    end

    // Selected bank only updates on this port's next read to it
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            rdata[p] = bank_rdata[sel_q[p]][p];
        end
    end

endmodule

/* hw/mpram_top.sv */
`timescale 1ns/1ps

module mpram_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en [mpram_cfg_pkg::READ_PORTS],
    input  mpram_types_pkg::addr_t raddr [mpram_cfg_pkg::READ_PORTS],
    input  logic                   we [mpram_cfg_pkg::WRITE_PORTS],
    input  mpram_types_pkg::addr_t waddr [mpram_cfg_pkg::WRITE_PORTS],
    input  mpram_types_pkg::word_t wdata [mpram_cfg_pkg::WRITE_PORTS],
    output mpram_types_pkg::word_t rdata [mpram_cfg_pkg::READ_PORTS],
    output logic                   ready
);

    import mpram_cfg_pkg::*;
    import mpram_types_pkg::*;

    logic       clear_active;
    bank_addr_t clear_addr;

    bank_addr_t bank_raddr [READ_PORTS];
    logic       bank_ren [NUM_BANKS][READ_PORTS];
    bank_addr_t bank_waddr [WRITE_PORTS];
    word_t      bank_wdata [WRITE_PORTS];
    logic       bank_we [NUM_BANKS][WRITE_PORTS];
    bank_sel_t  rsel [READ_PORTS];
    word_t      bank_rdata [NUM_BANKS][READ_PORTS];

    mpram_clear_seq i_clear_seq (
        .clk          (clk),
        .rst          (rst),
        .clear_active (clear_active),
        .clear_addr   (clear_addr),
        .ready        (ready)
    );

    mpram_bank_route i_bank_route (
        .en           (en),
        .raddr        (raddr),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .clear_active (clear_active),
        .clear_addr   (clear_addr),
        .bank_raddr   (bank_raddr),
        .bank_ren     (bank_ren),
        .bank_waddr   (bank_waddr),
        .bank_wdata   (bank_wdata),
        .bank_we      (bank_we),
        .rsel         (rsel)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mpram_bank i_bank (
            .clk        (clk),
            .bank_raddr (bank_raddr),
            .ren        (bank_ren[b]),
            .bank_waddr (bank_waddr),
            .bank_wdata (bank_wdata),
            .we         (bank_we[b]),
            .rdata      (bank_rdata[b])
        );
    end

    mpram_read_select i_read_select (
        .clk        (clk),
        .en         (en),
        .rsel       (rsel),
        .bank_rdata (bank_rdata),
        .rdata      (rdata)
    );

endmodule

/* bench/mpram_chk.sv */
`timescale 1ns/1ps

module mpram_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   en [mpram_cfg_pkg::READ_PORTS],
    input mpram_types_pkg::word_t rdata [mpram_cfg_pkg::READ_PORTS],
    input logic                   ready
);

    import mpram_cfg_pkg::*;

    // Ready is cleared asynchronously
    a_ready_low_in_reset: assert property (@(posedge clk) !rst |-> !ready)
        else $error("ready is high while reset is asserted");

    // Once up, ready stays up until the next reset
    a_ready_no_fall: assert property (@(posedge clk) disable iff (!rst) !$fell(ready))
        else $error("ready fell while reset is released");

    for (genvar p = 0; p < READ_PORTS; p++) begin : g_read
        a_rdata_known: assert property (
            @(posedge clk) disable iff (!rst)
            (ready && en[p]) |=> !$isunknown(rdata[p])
        ) else $error("rdata[%0d] has unknown bits after an enabled read", p);
    end

endmodule

bind mpram_top mpram_chk i_mpram_chk (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .rdata (rdata),
    .ready (ready)
);

/* bench/mpram_tb.sv */
`timescale 1ns/1ps

module mpram_tb;

    import mpram_cfg_pkg::*;
    import mpram_types_pkg::*;

    localparam int unsigned SEED = 32'hf1764ee6;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int READY_TIMEOUT = 50;
    localparam int RANDOM_CYCLES = 300;

    logic  clk;
    logic  rst;
    logic  en [READ_PORTS];
    addr_t raddr [READ_PORTS];
    logic  we [WRITE_PORTS];
    addr_t waddr [WRITE_PORTS];
    word_t wdata [WRITE_PORTS];
    word_t rdata [READ_PORTS];
    logic  ready;

    word_t model [DEPTH];       // Expected memory contents
    word_t held [READ_PORTS];   // Expected rdata per port
    logic  held_valid [READ_PORTS];
    int    mismatch_count;
    int    timeout_count;
    string test_name;

    mpram_top i_mpram_top (
        .clk   (clk),
        .rst   (rst),
        .en    (en),
        .raddr (raddr),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .rdata (rdata),
        .ready (ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic clear_inputs();
        for (int p = 0; p < READ_PORTS; p++) begin
            en[p] = 1'b0;
        end
        for (int w = 0; w < WRITE_PORTS; w++) begin
            we[w] = 1'b0;
        end
    endtask

    task automatic set_read(input int p, input addr_t a);
        en[p]    = 1'b1;
        raddr[p] = a;
    endtask

    task automatic set_write(input int w, input addr_t a, input word_t d);
        we[w]    = 1'b1;
        waddr[w] = a;
        wdata[w] = d;
    endtask

    // One clock edge; model is read-first and write port 1 lands last
    task automatic run_cycle();
        word_t expect_next [READ_PORTS];
        logic  read_now [READ_PORTS];
        for (int p = 0; p < READ_PORTS; p++) begin
            read_now[p] = en[p];
            if (en[p]) begin
                expect_next[p] = model[raddr[p]];
            end
        end
        for (int w = 0; w < WRITE_PORTS; w++) begin
            if (we[w]) begin
                model[waddr[w]] = wdata[w];
            end
        end
        @(negedge clk);
        for (int p = 0; p < READ_PORTS; p++) begin
            if (read_now[p]) begin
                held[p]       = expect_next[p];
                held_valid[p] = 1'b1;
            end
            if (held_valid[p] && rdata[p] !== held[p]) begin
                mismatch_count++;
                $display("Mismatch at %0t: %s, rdata[%0d] is %h, expected %h",
                         $time, test_name, p, rdata[p], held[p]);
            end
        end
        clear_inputs();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        clear_inputs();
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(negedge clk);
            if (ready !== 1'b0) begin
                mismatch_count++;
                $display("Mismatch at %0t: %s, ready is %b during reset, expected 0",
                         $time, test_name, ready);
            end
        end
        rst = 1'b1;
        for (int a = 0; a < DEPTH; a++) begin
            model[a] = CLEAR_VALUE;
        end
        for (int p = 0; p < READ_PORTS; p++) begin
            held_valid[p] = 1'b0;
        end
    endtask

    // Optionally drives writes during the clear, all of which must be dropped
    task automatic wait_ready(input logic junk);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < READY_TIMEOUT) begin
            if (junk) begin
                for (int w = 0; w < WRITE_PORTS; w++) begin
                    set_write(w, addr_t'($urandom_range(DEPTH - 1)), word_t'($urandom));
                end
            end
            @(negedge clk);
            n++;
        end
        clear_inputs();
        if (ready !== 1'b1) begin
            timeout_count++;
            $display("Timeout in %s: ready did not rise within %0d cycles after reset",
                     test_name, READY_TIMEOUT);
        end else if (n != BANK_SIZE + 1) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s, ready rose after %0d cycles, expected %0d",
                     $time, test_name, n, BANK_SIZE + 1);
        end
    endtask

    task automatic read_all();
        for (int a = 0; a < DEPTH; a++) begin
            set_read(0, addr_t'(a));
            set_read(1, addr_t'(DEPTH - 1 - a));
            run_cycle();
        end
    endtask

    task automatic test_clear();
        test_name = "clear";
        apply_reset();
        wait_ready(1'b0);
        read_all();
    endtask

    task automatic test_all_addresses();
        test_name = "all addresses";
        for (int w = 0; w < WRITE_PORTS; w++) begin
            for (int a = 0; a < DEPTH; a++) begin
                set_write(w, addr_t'(a), word_t'($urandom));
                run_cycle();
                set_read(0, addr_t'(a));
                set_read(1, addr_t'(a));
                run_cycle();
            end
        end
    endtask

    task automatic test_parallel_ports();
        addr_t a0;
        addr_t a1;
        test_name = "parallel ports";
        for (int b = 0; b < NUM_BANKS; b++) begin
            a0 = addr_t'(b * BANK_SIZE + $urandom_range(BANK_SIZE - 1));
            a1 = addr_t'(((b + 1) % NUM_BANKS) * BANK_SIZE + $urandom_range(BANK_SIZE - 1));
            set_write(0, a0, word_t'($urandom));
            set_write(1, a1, word_t'($urandom));
            run_cycle();
            set_read(0, a1); // Crossed on purpose
            set_read(1, a0);
            run_cycle();
            set_read(0, addr_t'(b * BANK_SIZE));
            set_read(1, addr_t'(b * BANK_SIZE + BANK_SIZE - 1));
            run_cycle();
        end
    endtask

    task automatic test_conflicts();
        addr_t a;
        word_t d0;
        word_t d1;
        word_t d_new;
        test_name = "conflicts";
        for (int b = 0; b < NUM_BANKS; b++) begin
            a  = addr_t'(b * BANK_SIZE + $urandom_range(BANK_SIZE - 1));
            d0 = word_t'($urandom);
            d1 = ~d0;
            set_write(0, a, d0);
            set_write(1, a, d1);
            run_cycle();
            set_read(0, a);
            run_cycle();
            if (rdata[0] !== d1) begin
                mismatch_count++;
                $display("Mismatch at %0t: %s, same-address write left %h, expected %h",
                         $time, test_name, rdata[0], d1);
            end
            // Read and write of one address at the same edge
            d_new = d1 ^ 16'h5a5a;
            set_write(1, a, d_new);
            set_read(0, a);
            set_read(1, a);
            run_cycle();
            if (rdata[0] !== d1 || rdata[1] !== d1) begin
                mismatch_count++;
                $display("Mismatch at %0t: %s, read during write gave %h/%h, expected %h",
                         $time, test_name, rdata[0], rdata[1], d1);
            end
            set_read(1, a);
            run_cycle();
            if (rdata[1] !== d_new) begin
                mismatch_count++;
                $display("Mismatch at %0t: %s, read after write gave %h, expected %h",
                         $time, test_name, rdata[1], d_new);
            end
        end
    endtask

    task automatic test_random_hold();
        addr_t a;
        test_name = "random traffic";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            for (int p = 0; p < READ_PORTS; p++) begin
                if ($urandom_range(1) == 1) begin
                    set_read(p, addr_t'($urandom_range(DEPTH - 1)));
                end
            end
            for (int w = 0; w < WRITE_PORTS; w++) begin
                if ($urandom_range(1) == 1) begin
                    set_write(w, addr_t'($urandom_range(DEPTH - 1)), word_t'($urandom));
                end
            end
            run_cycle();
        end
        // Overwrite the word under a held read, rdata must not move
        test_name = "read hold";
        a = addr_t'($urandom_range(DEPTH - 1));
        set_read(0, a);
        set_read(1, a);
        run_cycle();
        for (int i = 0; i < 4; i++) begin
            set_write(i % WRITE_PORTS, a, word_t'($urandom));
            run_cycle();
        end
        set_read(0, a);
        run_cycle();
    endtask

    task automatic test_reset_mid_run();
        test_name = "reset mid-run";
        for (int a = 0; a < DEPTH; a++) begin
            set_write(a % WRITE_PORTS, addr_t'(a), word_t'(16'h8000 | a)); // Never the clear value
            run_cycle();
        end
        apply_reset();
        wait_ready(1'b1);
        read_all();
    endtask

    initial begin
        void'($urandom(SEED));
        mismatch_count = 0;
        timeout_count  = 0;
        rst            = 1'b1;
        for (int p = 0; p < READ_PORTS; p++) begin
            en[p]         = 1'b0;
            raddr[p]      = '0;
            held_valid[p] = 1'b0;
        end
        for (int w = 0; w < WRITE_PORTS; w++) begin
            we[w]    = 1'b0;
            waddr[w] = '0;
            wdata[w] = '0;
        end
        test_clear();
        test_all_addresses();
        test_parallel_ports();
        test_conflicts();
        test_random_hold();
        test_reset_mid_run();
        $display("Error count: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/mpram_cfg_pkg.sv
hw/mpram_types_pkg.sv
hw/mpram_clear_seq.sv
hw/mpram_bank_route.sv
hw/mpram_bank.sv
hw/mpram_read_select.sv
hw/mpram_top.sv
bench/mpram_chk.sv
bench/mpram_tb.sv

/* Bender.yml */
package:
  name: mpram

sources:
  # Packages first, then RTL in dependency order
  - files:
      - hw/mpram_cfg_pkg.sv
      - hw/mpram_types_pkg.sv
      - hw/mpram_clear_seq.sv
      - hw/mpram_bank_route.sv
      - hw/mpram_bank.sv
      - hw/mpram_read_select.sv
      - hw/mpram_top.sv

  - target: simulation
    files:
      - bench/mpram_chk.sv
      - bench/mpram_tb.sv
